/* source/noc_pkg.sv */
package noc_pkg;

  localparam int flit_w = 32;
  typedef logic [flit_w-1:0] flit_t;

  // every flit carries its kind in the top bits
  localparam int kind_w = 2;
  typedef logic [kind_w-1:0] kind_t;

  localparam kind_t kind_header = 2'd1;
  localparam kind_t kind_body   = 2'd2;
  localparam kind_t kind_tail   = 2'd3;

  // mesh coordinates, 4 by 4
  localparam int coord_w = 2;
  typedef logic [coord_w-1:0] coord_t;

  // header flit layout below the kind field
  localparam int kind_lsb  = flit_w - kind_w;
  localparam int dst_x_lsb = kind_lsb - coord_w;
  localparam int dst_y_lsb = dst_x_lsb - coord_w;

  localparam int num_ports = 5;

  // one bit per port, at most one bit set
  typedef logic [num_ports-1:0] dir_t;

  localparam int dir_n = 0;
  localparam int dir_e = 1;
  localparam int dir_w = 2;
  localparam int dir_s = 3;
  localparam int dir_l = 4;

  // round-robin order used by every output arbiter
  localparam int rot_order [num_ports] = '{dir_l, dir_n, dir_e, dir_w, dir_s};

  localparam int fifo_depth = 4;
  localparam int ptr_w      = 2;

  typedef logic [ptr_w-1:0] ptr_t;

  // one extra bit so a full FIFO can be told from an empty one
  typedef logic [ptr_w:0] count_t;

endpackage

/* source/port_req_if.sv */
`timescale 1ns/100ps

// request side of one input port as seen by the crossbar
interface port_req_if;

  // output direction of the open packet, zero when nothing is requested
  noc_pkg::dir_t  req;

  // flit at the head of the input FIFO
  noc_pkg::flit_t head;

  logic           empty;

  // bit k is driven by output port k while it takes the head flit
  noc_pkg::dir_t  grant;

  modport source (
    output req,
    output head,
    output empty,
    input  grant
  );

  modport sink (
    input  req,
    input  head,
    input  empty,
    output grant
  );

endinterface

/* source/input_port.sv */
`timescale 1ns/100ps

module input_port (
  input  logic            clk,
  input  logic            rst,
  input  noc_pkg::flit_t  rx_flit,
  input  logic            rx_rts,
  output logic            rx_cts,
  input  noc_pkg::coord_t local_x,
  input  noc_pkg::coord_t local_y,
  port_req_if.source      req_src
);

  noc_pkg::flit_t  mem [noc_pkg::fifo_depth];
  noc_pkg::ptr_t   wr_ptr;
  noc_pkg::ptr_t   rd_ptr;
  noc_pkg::count_t count;

  logic push;
  logic pop;
  logic full;
  logic empty;

  noc_pkg::flit_t  head;
  noc_pkg::kind_t  head_kind;
  noc_pkg::coord_t dst_x;
  noc_pkg::coord_t dst_y;
  noc_pkg::dir_t   head_dir;

  // route of the packet currently passing through this port
  logic            open_q;
  noc_pkg::dir_t   dir_q;

  logic hdr_ready;
  logic stray;

  // receive handshake
  assign push = rx_rts && rx_cts;
  assign full = (count == noc_pkg::count_t'(noc_pkg::fifo_depth));

  // cts answers a waiting rts one cycle later and falls right after the transfer
  always_ff @(posedge clk) begin
    if (rst) begin
      rx_cts <= 1'b0;
    end else begin
      rx_cts <= rx_rts && !rx_cts && !full;
    end
  end

  // the FIFO pointers wrap on their own since the depth is a power of two
  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= rx_flit;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  assign empty     = (count == '0);
  assign head      = mem[rd_ptr];
  assign head_kind = head[noc_pkg::kind_lsb +: noc_pkg::kind_w];
  assign dst_x     = head[noc_pkg::dst_x_lsb +: noc_pkg::coord_w];
  assign dst_y     = head[noc_pkg::dst_y_lsb +: noc_pkg::coord_w];

  // XY routing settles x first and then y, and smaller y lies to the north
  always_comb begin
    head_dir = '0;
    if (dst_x > local_x) begin
      head_dir[noc_pkg::dir_e] = 1'b1;
    end else if (dst_x < local_x) begin
      head_dir[noc_pkg::dir_w] = 1'b1;
    end else if (dst_y < local_y) begin
      head_dir[noc_pkg::dir_n] = 1'b1;
    end else if (dst_y > local_y) begin
      head_dir[noc_pkg::dir_s] = 1'b1;
    end else begin
      head_dir[noc_pkg::dir_l] = 1'b1;
    end
  end

  assign hdr_ready = !empty && !open_q && (head_kind == noc_pkg::kind_header);

  // a body or tail flit outside any packet has no route and is dropped
  assign stray = !empty && !open_q &&
                 (head_kind inside {noc_pkg::kind_body, noc_pkg::kind_tail});

  assign pop = (|req_src.grant) || stray;

  always_ff @(posedge clk) begin
    if (rst) begin
      open_q <= 1'b0;
      dir_q  <= '0;
    end else if (hdr_ready) begin
      open_q <= 1'b1;
      dir_q  <= head_dir;
    end else if (pop && head_kind == noc_pkg::kind_tail) begin
      open_q <= 1'b0;
      dir_q  <= '0;
    end
  end

  // the header requests as soon as it reaches the head, dir_q takes over after that
  assign req_src.req   = open_q ? dir_q : (hdr_ready ? head_dir : '0);
  assign req_src.head  = head;
  assign req_src.empty = empty;

endmodule

/* source/output_port.sv */
`timescale 1ns/100ps

module output_port (
  input  logic           clk,
  input  logic           rst,
  output noc_pkg::flit_t tx_flit,
  output logic           tx_rts,
  input  logic           tx_dcts,
  input  noc_pkg::dir_t  req,
  input  noc_pkg::flit_t heads [noc_pkg::num_ports],
  input  noc_pkg::dir_t  empty,
  output noc_pkg::dir_t  grant
);

  // the one-hot arbiter state uses bit k+1 for slot k of the rotation
  typedef enum logic [noc_pkg::num_ports:0] {
    st_idle = 6'b000001,
    st_l    = 6'b000010,
    st_n    = 6'b000100,
    st_e    = 6'b001000,
    st_w    = 6'b010000,
    st_s    = 6'b100000
  } state_t;

  state_t state;
  state_t next_state;
  state_t state_d;

  logic rts_d;
  logic xfer;
  logic stall;
  logic sel_live;

  // selected input as a one-hot mask, and its rotation slot
  noc_pkg::dir_t sel_oh;
  int            cur_slot;

  assign xfer  = tx_rts && tx_dcts;
  assign stall = tx_rts && !tx_dcts;

  always_comb begin
    sel_oh   = '0;
    cur_slot = 0;
    for (int k = 0; k < noc_pkg::num_ports; k++) begin
      if (state[k+1]) begin
        sel_oh[noc_pkg::rot_order[k]] = 1'b1;
        cur_slot = k;
      end
    end
  end

  // scan the rotation starting at the current slot so a live requester keeps
  // the output, idle starts the scan at L
  always_comb begin
    int slot;
    next_state = st_idle;
    for (int k = noc_pkg::num_ports - 1; k >= 0; k--) begin
      slot = (cur_slot + k) % noc_pkg::num_ports;
      if (req[noc_pkg::rot_order[slot]]) begin
        next_state = state_t'(st_idle << (slot + 1));
      end
    end
  end

  // a waiting flit freezes the arbiter until the neighbour takes it
  assign state_d = stall ? state : next_state;

  // only offer a flit that the selected input still routes here
  assign sel_live = |(sel_oh & req & ~empty);

  assign rts_d = !xfer && sel_live;

  always_ff @(posedge clk) begin
    if (rst) begin
      state  <= st_idle;
      tx_rts <= 1'b0;
    end else begin
      state  <= state_d;
      tx_rts <= rts_d;
    end
  end

  // crossbar leg for this output
  always_comb begin
    tx_flit = '0;
    for (int k = 0; k < noc_pkg::num_ports; k++) begin
      if (sel_oh[k]) begin
        tx_flit = heads[k];
      end
    end
  end

  assign grant = sel_oh & {noc_pkg::num_ports{xfer}};

endmodule

/* source/noc_router.sv */
`timescale 1ns/100ps

module noc_router #(
  parameter noc_pkg::coord_t local_x = '0,
  parameter noc_pkg::coord_t local_y = '0
) (
  input  logic                          clk,
  input  logic                          rst,
  input  noc_pkg::flit_t                rx_flit [noc_pkg::num_ports],
  input  logic [noc_pkg::num_ports-1:0] rx_rts,
  output wire  [noc_pkg::num_ports-1:0] rx_cts,
  output wire  noc_pkg::flit_t          tx_flit [noc_pkg::num_ports],
  output wire  [noc_pkg::num_ports-1:0] tx_rts,
  input  logic [noc_pkg::num_ports-1:0] tx_dcts
);

  port_req_if port_if [noc_pkg::num_ports] ();

  // col_req[k] gathers bit k of every input's request, one bit per input
  wire noc_pkg::dir_t  col_req   [noc_pkg::num_ports];

  // out_grant[k] comes from output k, row_grant[i] goes back to input i
  wire noc_pkg::dir_t  out_grant [noc_pkg::num_ports];
  wire noc_pkg::dir_t  row_grant [noc_pkg::num_ports];

  wire noc_pkg::flit_t in_head   [noc_pkg::num_ports];
  wire noc_pkg::dir_t  in_empty;

  for (genvar i = 0; i < noc_pkg::num_ports; i++) begin : g_in
    input_port u_in (
      .clk     (clk),
      .rst     (rst),
      .rx_flit (rx_flit[i]),
      .rx_rts  (rx_rts[i]),
      .rx_cts  (rx_cts[i]),
      .local_x (local_x),
      .local_y (local_y),
      .req_src (port_if[i])
    );

    assign in_head[i]       = port_if[i].head;
    assign in_empty[i]      = port_if[i].empty;
    assign port_if[i].grant = row_grant[i];

    // transpose between the per-input and the per-output view
    for (genvar k = 0; k < noc_pkg::num_ports; k++) begin : g_xpose
      assign col_req[k][i]   = port_if[i].req[k];
      assign row_grant[i][k] = out_grant[k][i];
    end
  end

  for (genvar k = 0; k < noc_pkg::num_ports; k++) begin : g_out
    output_port u_out (
      .clk     (clk),
      .rst     (rst),
      .tx_flit (tx_flit[k]),
      .tx_rts  (tx_rts[k]),
      .tx_dcts (tx_dcts[k]),
      .req     (col_req[k]),
      .heads   (in_head),
      .empty   (in_empty),
      .grant   (out_grant[k])
    );
  end

endmodule

/* testbench/tb_noc_router.sv */
`timescale 1ns/100ps

module tb_noc_router;

  localparam int num_ports  = noc_pkg::num_ports;
  localparam int list_depth = 64;
  localparam int rcv_depth  = 128;
  localparam int max_wait   = 2000;

  logic clk = 1'b0;
  logic rst = 1'b1;

  noc_pkg::flit_t       rx_flit [num_ports] = '{default: '0};
  logic [num_ports-1:0] rx_rts  = '0;
  wire  [num_ports-1:0] rx_cts;
  wire  noc_pkg::flit_t tx_flit [num_ports];
  wire  [num_ports-1:0] tx_rts;
  logic [num_ports-1:0] tx_dcts = '0;

  // packets to inject per input and flits expected per output as read from the trace
  noc_pkg::flit_t send_mem [num_ports][list_depth];
  int             send_cnt [num_ports];
  noc_pkg::flit_t exp_mem  [num_ports][list_depth];
  int             exp_cnt  [num_ports];

  noc_pkg::flit_t rcv_mem  [num_ports][rcv_depth];
  int             rcv_cnt  [num_ports];
  int             sent     [num_ports];

  int   pass_num  = 0;
  bit   bp_on     = 1'b0;
  bit   trace_ok  = 1'b0;
  bit   timed_out = 1'b0;
  int   checks    = 0;
  int   errors    = 0;

  logic [15:0]          lfsr = 16'd21;
  bit                   seen_rts = 1'b0;
  logic [num_ports-1:0] out_xfer_q = '0;
  logic [num_ports-1:0] in_xfer_q  = '0;
  logic [num_ports-1:0] stall_q    = '0;
  noc_pkg::flit_t       held_flit [num_ports];

  noc_router #(
    .local_x (2'd1),
    .local_y (2'd1)
  ) u_dut (
    .clk     (clk),
    .rst     (rst),
    .rx_flit (rx_flit),
    .rx_rts  (rx_rts),
    .rx_cts  (rx_cts),
    .tx_flit (tx_flit),
    .tx_rts  (tx_rts),
    .tx_dcts (tx_dcts)
  );

  always #10 clk = ~clk;

  function automatic noc_pkg::kind_t kind_of(input noc_pkg::flit_t f);
    return f[noc_pkg::flit_w-1 -: noc_pkg::kind_w];
  endfunction

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic [15:0] n;
    n = s >> 1;
    if (s[0]) begin
      n = n ^ 16'hB400;
    end
    return n;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic load_trace();
    int          fd;
    int          code;
    int          dir;
    string       line;
    string       tag;
    logic [31:0] val;
    fd = $fopen("testbench/router_trace.txt", "r");
    if (fd == 0) begin
      errors++;
      $display("the trace file could not be opened");
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      code = $fgets(line, fd);
      code = $sscanf(line, "%s %d %h", tag, dir, val);
      if (code == 3 && dir >= 0 && dir < num_ports) begin
        if (tag == "S" && send_cnt[dir] < list_depth) begin
          send_mem[dir][send_cnt[dir]] = val;
          send_cnt[dir]++;
        end else if (tag == "E" && exp_cnt[dir] < list_depth) begin
          exp_mem[dir][exp_cnt[dir]] = val;
          exp_cnt[dir]++;
        end
      end
    end
    $fclose(fd);
    trace_ok = 1'b1;
  endtask

  // split one output's stream into packets and match each against the trace
  task automatic check_packets(input int k, input int base);
    bit used [list_depth];
    bit found;
    bit closed;
    int r;
    int j;
    int n;
    r = base;
    while (r < rcv_cnt[k]) begin
      found = 1'b0;
      j = 0;
      for (int e = 0; e < exp_cnt[k]; e++) begin
        if (!found && !used[e] && kind_of(exp_mem[k][e]) == noc_pkg::kind_header &&
            exp_mem[k][e] == rcv_mem[k][r]) begin
          found = 1'b1;
          j = e;
        end
      end
      checks++;
      assert (found) else begin
        errors++;
        $display("output %0d delivered flit %h where no expected packet starts",
                 k, rcv_mem[k][r]);
      end
      if (!found) begin
        r++;
      end else begin
        used[j] = 1'b1;
        n = 0;
        closed = 1'b0;
        while (!closed) begin
          checks++;
          assert (r + n < rcv_cnt[k] && j + n < exp_cnt[k]) else begin
            errors++;
            $display("packet %h on output %0d ends before its tail", exp_mem[k][j], k);
          end
          if (r + n >= rcv_cnt[k] || j + n >= exp_cnt[k]) begin
            closed = 1'b1;
          end else begin
            compare_value($sformatf("tx_flit[%0d]", k), rcv_mem[k][r+n], exp_mem[k][j+n]);
            closed = (kind_of(exp_mem[k][j+n]) == noc_pkg::kind_tail);
            n++;
          end
        end
        r = r + n;
      end
    end
    for (int e = 0; e < exp_cnt[k]; e++) begin
      if (kind_of(exp_mem[k][e]) == noc_pkg::kind_header) begin
        checks++;
        assert (used[e]) else begin
          errors++;
          $display("packet %h never arrived on output %0d", exp_mem[k][e], k);
        end
      end
    end
  endtask

  task automatic run_pass(input int pass, input bit bp);
    int base [num_ports];
    int cycles;
    int quiet;
    bit done;
    for (int k = 0; k < num_ports; k++) begin
      base[k] = rcv_cnt[k];
    end
    bp_on    <= bp;
    pass_num <= pass;
    cycles = 0;
    done = 1'b0;
    while (!done && cycles < max_wait) begin
      @(posedge clk);
      cycles++;
      done = 1'b1;
      for (int k = 0; k < num_ports; k++) begin
        if (rcv_cnt[k] < base[k] + exp_cnt[k]) begin
          done = 1'b0;
        end
      end
    end
    if (!done) begin
      errors++;
      timed_out = 1'b1;
      $display("timeout: outputs still missing flits in pass %0d", pass);
      return;
    end
    // let every link settle so late or duplicate flits get counted
    cycles = 0;
    quiet = 0;
    while (quiet < 8 && cycles < max_wait) begin
      @(posedge clk);
      cycles++;
      if (rx_rts == '0 && rx_cts == '0 && tx_rts == '0) begin
        quiet++;
      end else begin
        quiet = 0;
      end
    end
    if (quiet < 8) begin
      errors++;
      timed_out = 1'b1;
      $display("timeout: links did not go idle in pass %0d", pass);
      return;
    end
    for (int k = 0; k < num_ports; k++) begin
      compare_value($sformatf("flit count on output %0d", k), rcv_cnt[k] - base[k],
                    exp_cnt[k]);
      check_packets(k, base[k]);
    end
  endtask

  task automatic finish_run();
    $display("checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  endtask

  // neighbour senders offer one flit per rts and keep rts low for a cycle after each transfer
  always @(posedge clk) begin
    if (rst) begin
      rx_rts <= '0;
      for (int i = 0; i < num_ports; i++) begin
        sent[i] <= 0;
      end
    end else begin
      for (int i = 0; i < num_ports; i++) begin
        if (rx_rts[i] && rx_cts[i]) begin
          rx_rts[i] <= 1'b0;
          sent[i]   <= sent[i] + 1;
        end else if (!rx_rts[i] && sent[i] < send_cnt[i] * pass_num) begin
          rx_flit[i] <= send_mem[i][sent[i] % send_cnt[i]];
          rx_rts[i]  <= 1'b1;
        end
      end
    end
  end

  // neighbour receivers that the LFSR may stall
  always @(posedge clk) begin
    logic allow;
    if (rst) begin
      tx_dcts <= '0;
    end else begin
      for (int k = 0; k < num_ports; k++) begin
        allow = 1'b1;
        if (tx_rts[k] && tx_dcts[k]) begin
          if (rcv_cnt[k] < rcv_depth) begin
            rcv_mem[k][rcv_cnt[k]] <= tx_flit[k];
          end
          rcv_cnt[k] <= rcv_cnt[k] + 1;
        end else if (tx_rts[k] && bp_on) begin
          lfsr = lfsr_next(lfsr);
          allow = lfsr[0];
        end
        tx_dcts[k] <= tx_rts[k] && !tx_dcts[k] && allow;
      end
    end
  end

  // link rule and idle checks on every port
  always @(posedge clk) begin
    if (!rst) begin
      if (!seen_rts) begin
        compare_value("rx_cts", rx_cts, '0);
        compare_value("tx_rts", tx_rts, '0);
        if (rx_rts != '0) begin
          seen_rts = 1'b1;
        end
      end
      for (int k = 0; k < num_ports; k++) begin
        if (out_xfer_q[k]) begin
          compare_value($sformatf("tx_rts[%0d]", k), tx_rts[k], 1'b0);
        end
        if (in_xfer_q[k]) begin
          compare_value($sformatf("rx_cts[%0d]", k), rx_cts[k], 1'b0);
        end
        if (stall_q[k]) begin
          compare_value($sformatf("tx_rts[%0d]", k), tx_rts[k], 1'b1);
          compare_value($sformatf("tx_flit[%0d]", k), tx_flit[k], held_flit[k]);
        end
        out_xfer_q[k] = tx_rts[k] && tx_dcts[k];
        in_xfer_q[k]  = rx_rts[k] && rx_cts[k];
        stall_q[k]    = tx_rts[k] && !tx_dcts[k];
        held_flit[k]  = tx_flit[k];
      end
    end
  end

  initial begin
    load_trace();
    repeat (3) @(posedge clk);
    rst <= 1'b0;
    repeat (6) @(posedge clk);
    if (trace_ok) begin
      run_pass(1, 1'b0);
      if (!timed_out) begin
        run_pass(2, 1'b1);
      end
    end
    finish_run();
  end

endmodule

/* testbench/router_trace.txt */
# S <input dir> <flit hex> : flit sent into that input, in order per input
# E <output dir> <flit hex> : flit expected on that output, grouped per packet
# dirs: 0 north, 1 east, 2 west, 3 south, 4 local; router sits at x 1, y 1
S 4 74000101
S 4 80000102
S 4 C0000103
S 0 74000201
S 0 80000202
S 0 80000203
S 0 C0000204
S 2 54000301
S 2 80000302
S 2 C0000303
S 1 48000401
S 1 C0000402
S 3 50000501
S 3 80000502
S 3 C0000503
S 4 5C000601
S 4 80000602
S 4 C0000603
S 0 60000701
S 0 C0000702
S 1 54000801
S 1 80000802
S 1 C0000803
S 3 5C000901
S 3 C0000902
E 1 74000101
E 1 80000102
E 1 C0000103
E 1 74000201
E 1 80000202
E 1 80000203
E 1 C0000204
E 4 54000301
E 4 80000302
E 4 C0000303
E 2 48000401
E 2 C0000402
E 0 50000501
E 0 80000502
E 0 C0000503
E 3 5C000601
E 3 80000602
E 3 C0000603
E 1 60000701
E 1 C0000702
E 4 54000801
E 4 80000802
E 4 C0000803
E 3 5C000901
E 3 C0000902

/* project.f */
source/noc_pkg.sv
source/port_req_if.sv
source/input_port.sv
source/output_port.sv
source/noc_router.sv
testbench/tb_noc_router.sv
